// File: verilog.f
+incdir+source
source/ofdm_sample_pkg.sv
source/nr_frame_pkg.sv
source/cp_remover.sv
source/meta_fifo.sv
source/dft_engine.sv
source/subcarrier_mapper.sv
source/fft_demod.sv
test/fft_demod_checker.sv
test/fft_demod_tb.sv

// File: Makefile
TOP = fft_demod_tb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) +verilator+error+limit+10

clean:
	rm -rf obj_dir

// File: test/fft_demod_tb.sv
`timescale 1ns/1ps

`include "ofdm_params.svh"

module fft_demod_tb
    import ofdm_sample_pkg::*, nr_frame_pkg::*;
();

    localparam int  NUM_SYMS       = 20;
    localparam int  TIMEOUT_CYCLES = NUM_SYMS * 40 + 200;
    localparam real PI             = 3.14159265358979;

    typedef iq_sample_t [`FFT_LEN-1:0] window_t;

    logic       clk_i = 1'b0;
    logic       reset_ni;
    iq_sample_t s_data_i;
    in_user_t   s_user_i;
    logic       s_last_i;
    logic       s_valid_i;
    freq_bin_t  m_data_o;
    out_user_t  m_user_o;
    logic       m_last_o;
    logic       m_valid_o;
    logic       pbch_valid_o;
    logic       sss_valid_o;

    int           seed;
    int           cycle_cnt;
    int           beat;
    int           sym_out;
    window_t      win_q [$];
    symbol_meta_t meta_q [$];
    window_t      cur_win;
    symbol_meta_t cur_meta;

    fft_demod UUT (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .s_data_i     (s_data_i),
        .s_user_i     (s_user_i),
        .s_last_i     (s_last_i),
        .s_valid_i    (s_valid_i),
        .m_data_o     (m_data_o),
        .m_user_o     (m_user_o),
        .m_last_o     (m_last_o),
        .m_valid_o    (m_valid_o),
        .pbch_valid_o (pbch_valid_o),
        .sss_valid_o  (sss_valid_o)
    );

    bind fft_demod fft_demod_checker u_checker (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .m_valid_i    (m_valid_o),
        .m_last_i     (m_last_o),
        .pbch_valid_i (pbch_valid_o),
        .sss_valid_i  (sss_valid_o),
        .meta_push_i  (meta_push),
        .meta_pop_i   (meta_pop)
    );

    always #10 clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // X[k] = sum x[n] W^(kn) with W = cos - j sin scaled and rounded
    function automatic freq_bin_t dft_ref(input window_t window, input int k);
        real       ang;
        int        c;
        int        s;
        int        acc_re;
        int        acc_im;
        freq_bin_t res;
        acc_re = 0;
        acc_im = 0;
        for (int n = 0; n < `FFT_LEN; n++) begin
            ang = 2.0 * PI * ((k * n) % `FFT_LEN) / `FFT_LEN;
            c = int'($cos(ang) * `TWIDDLE_SCALE);
            s = int'(-$sin(ang) * `TWIDDLE_SCALE);
            acc_re += window[n].re * c - window[n].im * s;
            acc_im += window[n].re * s + window[n].im * c;
        end
        res.re = bin_part_t'(acc_re >>> `DFT_SHIFT);
        res.im = bin_part_t'(acc_im >>> `DFT_SHIFT);
        return res;
    endfunction

    function automatic string format_user(input out_user_t u);
        return $sformatf("sfn=%0d sf=%0d sym=%0d pbch=%0b",
                         u.meta.sfn, u.meta.subframe, u.meta.symbol, u.pbch_symbol);
    endfunction

    task automatic verify_bin(input string name, input freq_bin_t exp, input freq_bin_t got);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s expected re=%0d im=%0d got re=%0d im=%0d",
                                $time, name, exp.re, exp.im, got.re, got.im));
        end
    endtask

    task automatic compare_user(input string name, input out_user_t exp, input out_user_t got);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s expected %s got %s",
                                $time, name, format_user(exp), format_user(got)));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s expected %0b got %0b", $time, name, exp, got));
        end
    endtask

    // one symbol: the dropped part of the prefix, the window, then 0 to 3 extra beats
    task automatic send_symbol(input int idx);
        in_user_t   user;
        window_t    window;
        iq_sample_t smp;
        int         advance;
        int         total;
        user.cp_len        = cp_len_t'(2 + rand_below(6));
        user.meta.sfn      = sfn_t'(rand_below(1024));
        user.meta.subframe = subframe_t'(rand_below(10));
        user.meta.symbol   = symbol_num_t'(idx % 14);
        advance = int'(user.cp_len) - int'(user.cp_len) / 2;
        total   = advance + `FFT_LEN + rand_below(4);
        for (int i = 0; i < total; i++) begin
            if (rand_below(8) == 0) begin
                s_valid_i = 1'b0;
                s_last_i  = 1'b0;
                @(posedge clk_i);
                #1;
            end
            smp.re = sample_part_t'(rand_below(256) - 128);
            smp.im = sample_part_t'(rand_below(256) - 128);
            if (i >= advance && i < advance + `FFT_LEN) begin
                window[i - advance] = smp;
            end
            s_data_i  = smp;
            s_user_i  = user;
            s_last_i  = (i == total - 1);
            s_valid_i = 1'b1;
            @(posedge clk_i);
            #1;
            if (i == advance + `FFT_LEN - 1) begin
                win_q.push_back(window);
                meta_q.push_back(user.meta);
            end
        end
        s_valid_i = 1'b0;
        s_last_i  = 1'b0;
    endtask

    initial begin
        seed      = 32'hb295;
        reset_ni  = 1'b0;
        s_data_i  = '0;
        s_user_i  = '0;
        s_last_i  = 1'b0;
        s_valid_i = 1'b0;
        repeat (3) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;
        for (int i = 0; i < NUM_SYMS; i++) begin
            repeat (rand_below(4)) begin
                @(posedge clk_i);
                #1;
            end
            send_symbol(i);
        end
        while (sym_out < NUM_SYMS) @(posedge clk_i);
        // idle time in which a stray output beat would still be caught
        repeat (2 * `FFT_LEN) @(posedge clk_i);
        #1;
        if (UUT.u_checker.fail_count != 0) begin
            abort_run("a protocol assertion in the bound checker failed");
        end else if (sym_out != NUM_SYMS || beat != 0 || win_q.size() != 0) begin
            abort_run($sformatf("symbol count mismatch: %0d sent, %0d received",
                                NUM_SYMS, sym_out));
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

    // outputs change on the rising edge and are compared on the falling edge
    always @(negedge clk_i) begin
        int ssb_idx;
        int pos;
        out_user_t exp_user;
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles with %0d of %0d symbols received",
                                cycle_cnt, sym_out, NUM_SYMS));
        end
        if (UUT.u_checker.fail_count != 0) begin
            abort_run("a protocol assertion in the bound checker failed");
        end
        if (!reset_ni) begin
            check_flag("m_valid_o", 1'b0, m_valid_o);
            check_flag("m_last_o", 1'b0, m_last_o);
            check_flag("pbch_valid_o", 1'b0, pbch_valid_o);
            check_flag("sss_valid_o", 1'b0, sss_valid_o);
        end else if (m_valid_o) begin
            if (beat == 0) begin
                if (win_q.size() == 0) begin
                    abort_run("output beat seen before any symbol window was complete");
                end
                cur_win  = win_q.pop_front();
                cur_meta = meta_q.pop_front();
            end
            ssb_idx = sym_out % `SSB_PERIOD_SYMS;
            pos     = `BWP_START + beat;
            exp_user.meta        = cur_meta;
            exp_user.pbch_symbol = (ssb_idx == 0);
            verify_bin("m_data_o", dft_ref(cur_win, pos ^ (`FFT_LEN / 2)), m_data_o);
            compare_user("m_user_o", exp_user, m_user_o);
            check_flag("m_last_o", beat == `BWP_LEN - 1, m_last_o);
            check_flag("pbch_valid_o", ssb_idx == 0, pbch_valid_o);
            check_flag("sss_valid_o", (ssb_idx == 1) && (pos >= `SSS_START) &&
                       (pos < `SSS_START + `SSS_LEN), sss_valid_o);
            beat++;
            if (beat == `BWP_LEN) begin
                beat = 0;
                sym_out++;
            end
        end else begin
            check_flag("m_last_o", 1'b0, m_last_o);
            check_flag("pbch_valid_o", 1'b0, pbch_valid_o);
            check_flag("sss_valid_o", 1'b0, sss_valid_o);
        end
    end

endmodule

// File: test/fft_demod_checker.sv
`timescale 1ns/1ps

`include "ofdm_params.svh"

module fft_demod_checker (
    input logic clk_i,
    input logic reset_ni,
    input logic m_valid_i,
    input logic m_last_i,
    input logic pbch_valid_i,
    input logic sss_valid_i,
    input logic meta_push_i,
    input logic meta_pop_i
);

    // occupancy of the metadata FIFO, rebuilt from its push and pop strobes
    int fifo_level_q;

    // number of assertion failures so far
    int fail_count = 0;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            fifo_level_q <= 0;
        end else begin
            fifo_level_q <= fifo_level_q + int'(meta_push_i) - int'(meta_pop_i);
        end
    end

    last_needs_valid: assert property (@(posedge clk_i) disable iff (!reset_ni)
        m_last_i |-> m_valid_i)
        else begin
            $error("m_last_o is high without m_valid_o");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk_i)
        !reset_ni |=> !(m_valid_i || m_last_i || pbch_valid_i || sss_valid_i))
        else begin
            $error("an output strobe is high after a reset cycle");
            fail_count++;
        end

    no_push_when_full: assert property (@(posedge clk_i) disable iff (!reset_ni)
        meta_push_i |-> (fifo_level_q < `META_FIFO_DEPTH))
        else begin
            $error("metadata FIFO pushed while full");
            fail_count++;
        end

endmodule

// File: source/fft_demod.sv
`timescale 1ns/1ps

module fft_demod
    import ofdm_sample_pkg::*, nr_frame_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_sample_t s_data_i,
    input  in_user_t   s_user_i,
    input  logic       s_last_i,
    input  logic       s_valid_i,
    output freq_bin_t  m_data_o,
    output out_user_t  m_user_o,
    output logic       m_last_o,
    output logic       m_valid_o,
    output logic       pbch_valid_o,
    output logic       sss_valid_o
);

    iq_sample_t   win_sample;
    logic         win_valid;
    symbol_meta_t win_meta;
    logic         meta_push;
    symbol_meta_t meta_head;
    logic         meta_not_empty;
    logic         meta_pop;
    freq_bin_t    bin;
    logic         bin_valid;
    logic         bin_first;

    cp_remover u_cp_remover (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .s_data_i     (s_data_i),
        .s_user_i     (s_user_i),
        .s_last_i     (s_last_i),
        .s_valid_i    (s_valid_i),
        .win_sample_o (win_sample),
        .win_valid_o  (win_valid),
        .win_meta_o   (win_meta),
        .meta_push_o  (meta_push)
    );

    // the metadata bypasses the transform and rejoins at the mapper
    meta_fifo u_meta_fifo (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .push_i      (meta_push),
        .push_data_i (win_meta),
        .pop_i       (meta_pop),
        .head_o      (meta_head),
        .not_empty_o (meta_not_empty)
    );

    dft_engine u_dft_engine (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .win_sample_i (win_sample),
        .win_valid_i  (win_valid),
        .bin_o        (bin),
        .bin_valid_o  (bin_valid),
        .bin_first_o  (bin_first)
    );

    subcarrier_mapper u_subcarrier_mapper (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .bin_i            (bin),
        .bin_valid_i      (bin_valid),
        .bin_first_i      (bin_first),
        .meta_head_i      (meta_head),
        .meta_not_empty_i (meta_not_empty),
        .meta_pop_o       (meta_pop),
        .m_data_o         (m_data_o),
        .m_user_o         (m_user_o),
        .m_last_o         (m_last_o),
        .m_valid_o        (m_valid_o),
        .pbch_valid_o     (pbch_valid_o),
        .sss_valid_o      (sss_valid_o)
    );

endmodule

// File: source/subcarrier_mapper.sv
`timescale 1ns/1ps

`include "ofdm_params.svh"

module subcarrier_mapper
    import ofdm_sample_pkg::*, nr_frame_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_ni,
    input  freq_bin_t    bin_i,
    input  logic         bin_valid_i,
    input  logic         bin_first_i,
    input  symbol_meta_t meta_head_i,
    input  logic         meta_not_empty_i,
    output logic         meta_pop_o,
    output freq_bin_t    m_data_o,
    output out_user_t    m_user_o,
    output logic         m_last_o,
    output logic         m_valid_o,
    output logic         pbch_valid_o,
    output logic         sss_valid_o
);

    bin_idx_t   pos_q;
    bin_idx_t   cur_pos;
    ssb_count_t sym_cnt_q;
    logic       in_bwp;
    logic       in_sss;

    // bin_first realigns the position count at every symbol
    assign cur_pos = bin_first_i ? '0 : pos_q;

    assign in_bwp = (cur_pos >= `BWP_START) && (cur_pos < `BWP_START + `BWP_LEN);
    assign in_sss = (cur_pos >= `SSS_START) && (cur_pos < `SSS_START + `SSS_LEN);

    assign meta_pop_o = bin_valid_i && bin_first_i && meta_not_empty_i;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pos_q        <= '0;
            sym_cnt_q    <= '0;
            m_valid_o    <= 1'b0;
            m_last_o     <= 1'b0;
            pbch_valid_o <= 1'b0;
            sss_valid_o  <= 1'b0;
        end else begin
            m_valid_o    <= bin_valid_i && in_bwp;
            m_last_o     <= bin_valid_i && (cur_pos == `BWP_START + `BWP_LEN - 1);
            pbch_valid_o <= bin_valid_i && in_bwp && (sym_cnt_q == 0);
            sss_valid_o  <= bin_valid_i && in_sss && (sym_cnt_q == 1);
            if (bin_valid_i) begin
                pos_q <= cur_pos + 1'b1;
                if (cur_pos == bin_idx_t'(`FFT_LEN - 1)) begin
                    if (sym_cnt_q == ssb_count_t'(`SSB_PERIOD_SYMS - 1)) begin
                        sym_cnt_q <= '0;
                    end else begin
                        sym_cnt_q <= sym_cnt_q + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (bin_valid_i) begin
            m_data_o <= bin_i;
        end
        // metadata holds for the whole symbol
        if (bin_valid_i && bin_first_i) begin
            m_user_o.pbch_symbol <= (sym_cnt_q == 0);
            if (meta_not_empty_i) begin
                m_user_o.meta <= meta_head_i;
            end
        end
    end

endmodule

// File: source/dft_engine.sv
`timescale 1ns/1ps

`include "ofdm_params.svh"

module dft_engine
    import ofdm_sample_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_sample_t win_sample_i,
    input  logic       win_valid_i,
    output freq_bin_t  bin_o,
    output logic       bin_valid_o,
    output logic       bin_first_o
);

    localparam int  TW_W  = $clog2(`TWIDDLE_SCALE + 1) + 1;
    // 16 terms of two products each, plus sign
    localparam int  ACC_W = 2 * `SAMPLE_W + `NFFT + 1;
    localparam real PI    = 3.14159265358979;

    iq_sample_t             bank_mem [2][`FFT_LEN];
    logic signed [TW_W-1:0] tw_re [`FFT_LEN];
    logic signed [TW_W-1:0] tw_im [`FFT_LEN];

    logic                    wr_bank_q;
    logic                    rd_bank_q;
    logic                    drain_q;
    bin_idx_t                wr_idx_q;
    bin_idx_t                drain_pos_q;
    bin_idx_t                k_idx;
    bin_idx_t                tw_idx;
    iq_sample_t              smp;
    logic signed [ACC_W-1:0] acc_re;
    logic signed [ACC_W-1:0] acc_im;

    // W^m = cos(2 pi m / N) - j sin(2 pi m / N), rounded to the nearest step
    initial begin
        for (int m = 0; m < `FFT_LEN; m++) begin
            tw_re[m] = TW_W'(int'($cos(2.0 * PI * m / `FFT_LEN) * `TWIDDLE_SCALE));
            tw_im[m] = TW_W'(int'(-$sin(2.0 * PI * m / `FFT_LEN) * `TWIDDLE_SCALE));
        end
    end

    // output position p carries bin p xor N/2, so DC lands in the middle
    assign k_idx = drain_pos_q ^ bin_idx_t'(`FFT_LEN / 2);

    always_comb begin
        acc_re = '0;
        acc_im = '0;
        smp    = '0;
        tw_idx = '0;
        for (int n = 0; n < `FFT_LEN; n++) begin
            smp = bank_mem[rd_bank_q][n];
            // k*n wraps modulo N in the 4-bit index
            tw_idx = bin_idx_t'(k_idx * bin_idx_t'(n));
            acc_re = acc_re + smp.re * tw_re[tw_idx] - smp.im * tw_im[tw_idx];
            acc_im = acc_im + smp.re * tw_im[tw_idx] + smp.im * tw_re[tw_idx];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_bank_q   <= 1'b0;
            rd_bank_q   <= 1'b0;
            wr_idx_q    <= '0;
            drain_q     <= 1'b0;
            drain_pos_q <= '0;
            bin_valid_o <= 1'b0;
            bin_first_o <= 1'b0;
        end else begin
            bin_valid_o <= drain_q;
            bin_first_o <= drain_q && (drain_pos_q == '0);
            if (drain_q) begin
                drain_pos_q <= drain_pos_q + 1'b1;
                if (drain_pos_q == bin_idx_t'(`FFT_LEN - 1)) begin
                    drain_q <= 1'b0;
                end
            end
            if (win_valid_i) begin
                wr_idx_q <= wr_idx_q + 1'b1;
                if (wr_idx_q == bin_idx_t'(`FFT_LEN - 1)) begin
                    // the full bank drains while the other one fills
                    wr_bank_q   <= ~wr_bank_q;
                    rd_bank_q   <= wr_bank_q;
                    drain_q     <= 1'b1;
                    drain_pos_q <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (win_valid_i) begin
            bank_mem[wr_bank_q][wr_idx_q] <= win_sample_i;
        end
        if (drain_q) begin
            bin_o.re <= bin_part_t'(acc_re >>> `DFT_SHIFT);
            bin_o.im <= bin_part_t'(acc_im >>> `DFT_SHIFT);
        end
    end

endmodule

// File: source/meta_fifo.sv
`timescale 1ns/1ps

`include "ofdm_params.svh"

module meta_fifo
    import nr_frame_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_ni,
    input  logic         push_i,
    input  symbol_meta_t push_data_i,
    input  logic         pop_i,
    output symbol_meta_t head_o,
    output logic         not_empty_o
);

    localparam int PTR_W = $clog2(`META_FIFO_DEPTH);

    symbol_meta_t     mem [`META_FIFO_DEPTH];
    logic [PTR_W:0]   wr_ptr_q;
    logic [PTR_W:0]   rd_ptr_q;
    logic             full;

    // the extra pointer bit tells a full buffer from an empty one
    assign not_empty_o = (wr_ptr_q != rd_ptr_q);
    assign full        = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                         (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

    assign head_o = mem[rd_ptr_q[PTR_W-1:0]];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i && !full) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i && not_empty_o) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i && !full) begin
            mem[wr_ptr_q[PTR_W-1:0]] <= push_data_i;
        end
    end

endmodule

// File: source/cp_remover.sv
`timescale 1ns/1ps

`include "ofdm_params.svh"

module cp_remover
    import ofdm_sample_pkg::*, nr_frame_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_ni,
    input  iq_sample_t   s_data_i,
    input  in_user_t     s_user_i,
    input  logic         s_last_i,
    input  logic         s_valid_i,
    output iq_sample_t   win_sample_o,
    output logic         win_valid_o,
    output symbol_meta_t win_meta_o,
    output logic         meta_push_o
);

    skip_state_t state_q;
    in_user_t    user_q;
    in_user_t    cur_user;
    cp_len_t     skip_cnt_q;
    cp_len_t     skip_len;
    bin_idx_t    take_cnt_q;
    logic        first_beat_q;

    // the prefix length and the metadata of a symbol come from its first beat
    assign cur_user = first_beat_q ? s_user_i : user_q;

    // dropping only the first half of the prefix starts the window half a CP early
    assign skip_len = cur_user.cp_len - (cur_user.cp_len >> 1);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= SKIP_CP;
            skip_cnt_q   <= '0;
            take_cnt_q   <= '0;
            first_beat_q <= 1'b1;
            win_valid_o  <= 1'b0;
            meta_push_o  <= 1'b0;
        end else begin
            win_valid_o <= 1'b0;
            meta_push_o <= 1'b0;
            if (s_valid_i) begin
                first_beat_q <= s_last_i;
                case (state_q)
                    SKIP_CP: begin
                        if (skip_cnt_q == skip_len - 1'b1) begin
                            state_q    <= TAKE_SYMBOL;
                            skip_cnt_q <= '0;
                        end else begin
                            skip_cnt_q <= skip_cnt_q + 1'b1;
                        end
                    end
                    TAKE_SYMBOL: begin
                        win_valid_o <= 1'b1;
                        take_cnt_q  <= take_cnt_q + 1'b1;
                        if (take_cnt_q == bin_idx_t'(`FFT_LEN - 1)) begin
                            meta_push_o <= 1'b1;
                            // a window that ends on tlast has no tail to drop
                            state_q <= s_last_i ? SKIP_CP : SKIP_TAIL;
                        end
                    end
                    SKIP_TAIL: begin
                        if (s_last_i) begin
                            state_q <= SKIP_CP;
                        end
                    end
                    default: begin
                        state_q <= SKIP_CP;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_valid_i) begin
            win_sample_o <= s_data_i;
            win_meta_o   <= cur_user.meta;
            if (first_beat_q) begin
                user_q <= s_user_i;
            end
        end
    end

endmodule

// File: source/nr_frame_pkg.sv
`include "ofdm_params.svh"

package nr_frame_pkg;

    typedef logic [9:0] sfn_t;
    typedef logic [4:0] subframe_t;
    typedef logic [3:0] symbol_num_t;
    typedef logic [`CP_LEN_W-1:0] cp_len_t;

    typedef struct packed {
        sfn_t        sfn;
        subframe_t   subframe;
        symbol_num_t symbol;
    } symbol_meta_t;

    typedef struct packed {
        symbol_meta_t meta;
        cp_len_t      cp_len;
    } in_user_t;

    typedef struct packed {
        symbol_meta_t meta;
        logic         pbch_symbol;
    } out_user_t;

    typedef logic [$clog2(`SSB_PERIOD_SYMS)-1:0] ssb_count_t;

    typedef enum logic [1:0] {SKIP_CP, TAKE_SYMBOL, SKIP_TAIL} skip_state_t;

endpackage

// File: source/ofdm_sample_pkg.sv
`include "ofdm_params.svh"

package ofdm_sample_pkg;

    // time-domain input sample
    typedef logic signed [`SAMPLE_W-1:0] sample_part_t;

    typedef struct packed {
        sample_part_t im;
        sample_part_t re;
    } iq_sample_t;

    // frequency-domain output bin
    typedef logic signed [`BIN_W-1:0] bin_part_t;

    typedef struct packed {
        bin_part_t im;
        bin_part_t re;
    } freq_bin_t;

    // counts bins and window samples within one symbol
    typedef logic [`NFFT-1:0] bin_idx_t;

endpackage

// File: source/ofdm_params.svh
`ifndef OFDM_PARAMS_SVH
`define OFDM_PARAMS_SVH

// transform size and its log2
`define FFT_LEN 16
`define NFFT 4

// widths of one real or imaginary part at the input and at the output
`define SAMPLE_W 8
`define BIN_W 14

// twiddles are scaled to 127 and the sums are shifted back by 7 bits
`define TWIDDLE_SCALE 127
`define DFT_SHIFT 7

// windows in shifted bin order
`define BWP_START 2
`define BWP_LEN 12
`define SSS_START 4
`define SSS_LEN 7

`define SSB_PERIOD_SYMS 8
`define CP_LEN_W 3
`define META_FIFO_DEPTH 4

`endif
